//--- logic/lsu_replay_pkg.sv
// ----------------------------------------------------------
// shared sizes and types of the lsu replay queue
// queue size is fixed at 8, and the hazard index union is
// built around it, so the size does not scale on its own
// ----------------------------------------------------------

package lsu_replay_pkg;

  localparam int RQ_SIZE       = 8;
  localparam int RQ_W          = 3;
  localparam int STQ_SIZE      = 8;
  localparam int MISS_SIZE     = 4;
  // four pipeline stages can still deliver hazards after almost-full rises
  localparam int RQ_ALMOST_LVL = RQ_SIZE - 4;

  typedef enum logic [1:0] {
    HAZ_STQ_WAIT,     // older stores pending
    HAZ_MISS_WAIT,    // miss entries not refilled
    HAZ_MISS_FULL,    // miss unit had no room
    HAZ_L1D_CONFLICT  // bank conflict, retry at once
  } haz_typ_e;

  // one hazard word, read by kind
  typedef union packed {
    logic [STQ_SIZE-1:0] stq_mask;
    struct packed {
      logic [STQ_SIZE-MISS_SIZE-1:0] unused;
      logic [MISS_SIZE-1:0]          miss_mask;
    } miss;
  } haz_index_u;

  typedef struct packed {
    logic [31:0] inst;
    logic [39:0] paddr;
    logic [5:0]  rob_id;
    logic        is_uc;  // uncached access
  } replay_payload_t;

  typedef logic [RQ_W-1:0] rq_id_t;

endpackage

//--- logic/replay_alloc_if.sv
// ----------------------------------------------------------
// slot allocation and release between allocator and array
// release ids always name an occupied slot
// ----------------------------------------------------------
`timescale 1ns/100ps

interface replay_alloc_if
  import lsu_replay_pkg::*;
();

  logic   alloc_valid;   // slot written on this edge
  rq_id_t alloc_id;
  logic   release_valid; // slot back to free list on this edge
  rq_id_t release_id;

  modport allocator (
    output alloc_valid, alloc_id,
    input  release_valid, release_id
  );

  modport array (
    input  alloc_valid, alloc_id,
    output release_valid, release_id
  );

endinterface

//--- logic/replay_issue_if.sv
// ----------------------------------------------------------
// resolved slots and selected entry between array and arbiter
// sel_* fields are combinational reads at sel_id
// ----------------------------------------------------------
`timescale 1ns/100ps

interface replay_issue_if
  import lsu_replay_pkg::*;
();

  logic [RQ_SIZE-1:0] resolved_vec;  // live and (index zero or dead)
  logic [RQ_SIZE-1:0] dead_vec;
  replay_payload_t    sel_payload;
  haz_typ_e           sel_typ;
  haz_index_u         sel_index;
  rq_id_t             sel_id;
  logic               fire;          // selected slot leaves this edge

  modport array (
    output resolved_vec, dead_vec, sel_payload, sel_typ, sel_index,
    input  sel_id, fire
  );

  modport arbiter (
    input  resolved_vec, dead_vec, sel_payload, sel_typ, sel_index,
    output sel_id, fire
  );

endinterface

//--- logic/replay_slot_alloc.sv
// ----------------------------------------------------------
// free-slot bitmap and occupancy counter of the replay queue
// hands out the lowest free slot, one accept per cycle
// released slots count as free one edge after release
// ----------------------------------------------------------
`timescale 1ns/100ps

module replay_slot_alloc
  import lsu_replay_pkg::*;
(
  input  logic               i_clk,
  input  logic               i_reset_n,
  input  logic               i_haz_valid,
  output logic               o_haz_ready,
  output logic               o_almost_full,
  replay_alloc_if.allocator  alloc
);

  logic [RQ_SIZE-1:0] r_free;   // 1 = slot free
  logic [RQ_W:0]      r_count;  // occupied slots
  rq_id_t             w_free_id;

  // lowest free slot
  always_comb begin
    w_free_id = '0;
    for (int i = RQ_SIZE - 1; i >= 0; i--) begin
      if (r_free[i]) begin
        w_free_id = rq_id_t'(i);
      end
    end
  end

  assign o_haz_ready     = r_count != (RQ_W+1)'(RQ_SIZE);
  assign o_almost_full   = r_count >= (RQ_W+1)'(RQ_ALMOST_LVL);
  assign alloc.alloc_valid = i_haz_valid & o_haz_ready;
  assign alloc.alloc_id    = w_free_id;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_free  <= '1;
      r_count <= '0;
    end else begin
      if (alloc.alloc_valid) begin
        r_free[alloc.alloc_id] <= 1'b0;
      end
      if (alloc.release_valid) begin
        r_free[alloc.release_id] <= 1'b1;  // never the slot just taken
      end
      case ({alloc.alloc_valid, alloc.release_valid})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;
      endcase
    end
  end

endmodule

//--- logic/replay_hazard_array.sv
// ----------------------------------------------------------
// per-slot hazard state and payload storage
// resolution inputs act on the edge after they are sampled
// a flush marks live slots dead, the new accept survives
// miss-wait entries get their unused index bits cleared
// ----------------------------------------------------------
`timescale 1ns/100ps

module replay_hazard_array
  import lsu_replay_pkg::*;
(
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  haz_typ_e             i_haz_typ,
  input  haz_index_u           i_haz_index,
  input  replay_payload_t      i_haz_payload,
  input  logic [STQ_SIZE-1:0]  i_stq_resolve_mask,
  input  logic                 i_miss_resolve_valid,
  input  logic [MISS_SIZE-1:0] i_miss_resolve_oh,
  input  logic                 i_miss_full,
  input  logic                 i_flush,
  replay_alloc_if.array        alloc,
  replay_issue_if.array        issue
);

  logic [RQ_SIZE-1:0] r_valid;
  logic [RQ_SIZE-1:0] r_dead;
  haz_typ_e           r_typ     [RQ_SIZE];
  haz_index_u         r_index   [RQ_SIZE];
  replay_payload_t    r_payload [RQ_SIZE];
  haz_index_u         w_new_index;
  logic               r_release_valid;
  rq_id_t             r_release_id;

  // index as written at accept
  always_comb begin
    w_new_index = i_haz_index;
    case (i_haz_typ)
      HAZ_MISS_WAIT:    w_new_index.miss.unused = '0;
      HAZ_L1D_CONFLICT: w_new_index = '0;  // replays at once
      default:          w_new_index = i_haz_index;
    endcase
  end

  // ----------------------------------------------------------
  // slot state
  // ----------------------------------------------------------
  for (genvar q = 0; q < RQ_SIZE; q++) begin : g_slot
    logic w_alloc_hit;
    logic w_fire_hit;

    assign w_alloc_hit = alloc.alloc_valid & (alloc.alloc_id == rq_id_t'(q));
    assign w_fire_hit  = issue.fire & (issue.sel_id == rq_id_t'(q));

    always_ff @(posedge i_clk, negedge i_reset_n) begin
      if (!i_reset_n) begin
        r_valid[q] <= 1'b0;
        r_dead[q]  <= 1'b0;
        r_typ[q]   <= HAZ_STQ_WAIT;
        r_index[q] <= '0;
      end else if (w_alloc_hit) begin
        r_valid[q] <= 1'b1;
        r_dead[q]  <= 1'b0;
        r_typ[q]   <= i_haz_typ;
        r_index[q] <= w_new_index;
      end else if (w_fire_hit) begin
        r_valid[q] <= 1'b0;
      end else if (r_valid[q]) begin
        if (i_flush) begin
          r_dead[q] <= 1'b1;
        end
        // decode the index word by hazard kind
        case (r_typ[q])
          HAZ_STQ_WAIT:
            r_index[q].stq_mask <= r_index[q].stq_mask & ~i_stq_resolve_mask;
          HAZ_MISS_WAIT: begin
            if (i_miss_resolve_valid) begin
              r_index[q].miss.miss_mask <= r_index[q].miss.miss_mask & ~i_miss_resolve_oh;
            end
          end
          HAZ_MISS_FULL: begin
            if (!i_miss_full) begin
              r_index[q] <= '0;
            end
          end
          default: r_index[q] <= '0;
        endcase
      end
    end

    assign issue.resolved_vec[q] = r_valid[q] & ((r_index[q] == '0) | r_dead[q]);
    assign issue.dead_vec[q]     = r_valid[q] & r_dead[q];
  end

  // payload registers, written at accept
  always_ff @(posedge i_clk) begin
    if (alloc.alloc_valid) begin
      r_payload[alloc.alloc_id] <= i_haz_payload;
    end
  end

  assign issue.sel_payload = r_payload[issue.sel_id];
  assign issue.sel_typ     = r_typ[issue.sel_id];
  assign issue.sel_index   = r_index[issue.sel_id];

  // ----------------------------------------------------------
  // release, one cycle after fire
  // ----------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_release_valid <= 1'b0;
    end else begin
      r_release_valid <= issue.fire;
    end
  end

  always_ff @(posedge i_clk) begin
    if (issue.fire) begin
      r_release_id <= issue.sel_id;
    end
  end

  assign alloc.release_valid = r_release_valid;
  assign alloc.release_id    = r_release_id;

endmodule

//--- logic/replay_issue_arb.sv
// ----------------------------------------------------------
// rotating pick of a resolved slot and replay request
// selection is held while the request waits for ready
// dead slots leave one per cycle without a request
// ----------------------------------------------------------
`timescale 1ns/100ps

module replay_issue_arb
  import lsu_replay_pkg::*;
(
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  logic             i_req_ready,
  output logic             o_req_valid,
  output replay_payload_t  o_req_payload,
  output haz_typ_e         o_req_typ,
  replay_issue_if.arbiter  issue
);

  rq_id_t r_ptr;      // search starts here
  rq_id_t r_lock_id;
  logic   r_lock;     // request stalled last cycle
  rq_id_t w_pick_id;
  logic   w_sel_dead;

  // first resolved slot at or above the pointer, wrapping
  always_comb begin
    rq_id_t w_idx;
    w_pick_id = r_ptr;
    for (int i = RQ_SIZE - 1; i >= 0; i--) begin
      w_idx = r_ptr + rq_id_t'(i);
      if (issue.resolved_vec[w_idx]) begin
        w_pick_id = w_idx;
      end
    end
  end

  assign issue.sel_id = r_lock ? r_lock_id : w_pick_id;
  assign w_sel_dead   = issue.resolved_vec[issue.sel_id] & issue.dead_vec[issue.sel_id];
  assign o_req_valid  = issue.resolved_vec[issue.sel_id] & ~issue.dead_vec[issue.sel_id] &
                        (issue.sel_index == '0);
  assign issue.fire   = w_sel_dead | (o_req_valid & i_req_ready);

  assign o_req_payload = issue.sel_payload;
  assign o_req_typ     = issue.sel_typ;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ptr     <= '0;
      r_lock    <= 1'b0;
      r_lock_id <= '0;
    end else begin
      r_lock    <= o_req_valid & ~i_req_ready;
      r_lock_id <= issue.sel_id;
      if (o_req_valid & i_req_ready) begin
        r_ptr <= rq_id_t'(issue.sel_id + 1'b1);  // past the issued slot
      end
    end
  end

endmodule

//--- logic/lsu_replay_top.sv
// ----------------------------------------------------------
// lsu replay queue, 8 slots
// hazards enter by valid/ready, replays leave by valid/ready
// flush kills every parked entry, not the one accepted with it
// ----------------------------------------------------------
`timescale 1ns/100ps

module lsu_replay_top
  import lsu_replay_pkg::*;
(
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  // hazard entry
  input  logic                 i_haz_valid,
  output logic                 o_haz_ready,
  input  haz_typ_e             i_haz_typ,
  input  haz_index_u           i_haz_index,
  input  replay_payload_t      i_haz_payload,
  // resolution and miss unit status
  input  logic [STQ_SIZE-1:0]  i_stq_resolve_mask,
  input  logic                 i_miss_resolve_valid,
  input  logic [MISS_SIZE-1:0] i_miss_resolve_oh,
  input  logic                 i_miss_full,
  input  logic                 i_flush,
  // replay request
  output logic                 o_req_valid,
  input  logic                 i_req_ready,
  output replay_payload_t      o_req_payload,
  output haz_typ_e             o_req_typ,
  output logic                 o_almost_full
);

  replay_alloc_if alloc_if_i ();
  replay_issue_if issue_if_i ();

  replay_slot_alloc slot_alloc_i (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_haz_valid   (i_haz_valid),
    .o_haz_ready   (o_haz_ready),
    .o_almost_full (o_almost_full),
    .alloc         (alloc_if_i.allocator)
  );

  replay_hazard_array hazard_array_i (
    .i_clk                (i_clk),
    .i_reset_n            (i_reset_n),
    .i_haz_typ            (i_haz_typ),
    .i_haz_index          (i_haz_index),
    .i_haz_payload        (i_haz_payload),
    .i_stq_resolve_mask   (i_stq_resolve_mask),
    .i_miss_resolve_valid (i_miss_resolve_valid),
    .i_miss_resolve_oh    (i_miss_resolve_oh),
    .i_miss_full          (i_miss_full),
    .i_flush              (i_flush),
    .alloc                (alloc_if_i.array),
    .issue                (issue_if_i.array)
  );

  replay_issue_arb issue_arb_i (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_req_ready   (i_req_ready),
    .o_req_valid   (o_req_valid),
    .o_req_payload (o_req_payload),
    .o_req_typ     (o_req_typ),
    .issue         (issue_if_i.arbiter)
  );

endmodule

//--- verification/lsu_replay_sva.sv
// ----------------------------------------------------------
// handshake, occupancy and reset rules of the replay queue
// a flush may drop a stalled request, so it is excluded
// ----------------------------------------------------------
`timescale 1ns/100ps

module lsu_replay_sva
  import lsu_replay_pkg::*;
(
  input logic            i_clk,
  input logic            i_reset_n,
  input logic            i_flush,
  input logic            o_req_valid,
  input logic            i_req_ready,
  input replay_payload_t o_req_payload,
  input haz_typ_e        o_req_typ,
  input logic            o_haz_ready,
  input logic            o_almost_full,
  input logic [RQ_W:0]   i_count  // occupied slots
);

  a_req_stable: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (o_req_valid && !i_req_ready && !i_flush) |=>
      (o_req_valid && $stable(o_req_payload) && $stable(o_req_typ)))
    else $error("request changed under back-pressure");

  a_no_req_empty: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_req_valid |-> i_count != '0)
    else $error("request raised while no slot is occupied");

  a_reset_quiet: assert property (@(posedge i_clk)
    !i_reset_n |-> (!o_req_valid && !o_almost_full && o_haz_ready))
    else $error("outputs not quiet in reset");

endmodule

bind lsu_replay_top lsu_replay_sva lsu_replay_sva_i (
  .i_clk         (i_clk),
  .i_reset_n     (i_reset_n),
  .i_flush       (i_flush),
  .o_req_valid   (o_req_valid),
  .i_req_ready   (i_req_ready),
  .o_req_payload (o_req_payload),
  .o_req_typ     (o_req_typ),
  .o_haz_ready   (o_haz_ready),
  .o_almost_full (o_almost_full),
  .i_count       (slot_alloc_i.r_count)
);

//--- verification/tb_lsu_replay.sv
// ----------------------------------------------------------
// random testbench of the lsu replay queue
// payload inst carries the op number so requests map to entries
// occupancy is not checked while flushed entries drain
// ----------------------------------------------------------
`timescale 1ns/100ps

module tb_lsu_replay
  import lsu_replay_pkg::*;
();

  localparam int NUM_OPS   = 400;
  localparam int DRAIN_CYC = 24;  // dead slots leave one per cycle

  typedef struct packed {
    replay_payload_t pl;
    haz_typ_e        typ;
    haz_index_u      idx;
    logic            dead;
  } model_ent_t;

  logic i_clk, i_reset_n, i_haz_valid, o_haz_ready, i_miss_resolve_valid;
  logic i_miss_full, i_flush, o_req_valid, i_req_ready, o_almost_full;
  haz_typ_e i_haz_typ, o_req_typ;
  haz_index_u i_haz_index;
  replay_payload_t i_haz_payload, o_req_payload;
  logic [STQ_SIZE-1:0] i_stq_resolve_mask;
  logic [MISS_SIZE-1:0] i_miss_resolve_oh;

  model_ent_t model_q[$];
  integer seed = 32'h1ed1_edf4;
  int sent = 0;
  int drain = 0;
  int occ;
  logic rel_pend = 1'b0;  // live issue waiting for release

  lsu_replay_top lsu_replay_top_i (.*);

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  // ----------------------------------------------------------
  // failure and compare helpers
  // ----------------------------------------------------------
  task automatic fail_stop();
    $display("ERRORS FOUND");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_payload(input replay_payload_t exp, input replay_payload_t got);
    if (got !== exp) begin
      $display("MISMATCH o_req_payload exp=%h got=%h", exp, got);
      fail_stop();
    end
  endtask

  task automatic check_typ(input haz_typ_e exp, input haz_typ_e got);
    if (got !== exp) begin
      $display("MISMATCH o_req_typ exp=%h got=%h", exp, got);
      fail_stop();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      $display("MISMATCH %s exp=%h got=%h", name, exp, got);
      fail_stop();
    end
  endtask

  // resolved test, union read by kind
  function automatic logic is_resolved(input model_ent_t e);
    case (e.typ)
      HAZ_STQ_WAIT:  return e.idx.stq_mask == '0;
      HAZ_MISS_WAIT: return e.idx.miss.miss_mask == '0;
      default:       return e.idx == '0;
    endcase
  endfunction

  task automatic resolve_model();
    foreach (model_q[k]) begin
      case (model_q[k].typ)
        HAZ_STQ_WAIT: model_q[k].idx.stq_mask &= ~i_stq_resolve_mask;
        HAZ_MISS_WAIT: begin
          if (i_miss_resolve_valid) model_q[k].idx.miss.miss_mask &= ~i_miss_resolve_oh;
        end
        HAZ_MISS_FULL: begin
          if (!i_miss_full) model_q[k].idx = '0;
        end
        default: model_q[k].idx = '0;
      endcase
    end
  endtask

  task automatic check_request(output int hit);
    hit = -1;
    foreach (model_q[k]) begin
      if (model_q[k].pl.inst == o_req_payload.inst) hit = k;
    end
    if (hit < 0) begin
      $display("request for an entry that is not parked, inst %h", o_req_payload.inst);
      fail_stop();
    end else if (model_q[hit].dead) begin
      $display("flushed entry was requested, inst %h", o_req_payload.inst);
      fail_stop();
    end else if (!is_resolved(model_q[hit])) begin
      $display("entry requested before its hazard resolved, inst %h", o_req_payload.inst);
      fail_stop();
    end
    check_typ(model_q[hit].typ, o_req_typ);
    check_payload(model_q[hit].pl, o_req_payload);
  endtask

  task automatic drive_inputs();
    logic [31:0] r;
    r = $random(seed);
    i_haz_valid = (drain == 0) && (sent < NUM_OPS) && r[0];
    i_haz_typ   = haz_typ_e'(r[2:1]);
    i_haz_index = STQ_SIZE'($random(seed));
    i_haz_payload.inst   = sent;
    i_haz_payload.paddr  = {r[31:24], $random(seed)};
    i_haz_payload.rob_id = r[13:8];
    i_haz_payload.is_uc  = r[14];
    i_req_ready = (drain != 0) || r[15] || r[16];
    i_stq_resolve_mask = STQ_SIZE'($random(seed) & $random(seed) & $random(seed));
    i_miss_resolve_valid = r[17];
    i_miss_resolve_oh = MISS_SIZE'(1) << r[19:18];
    i_miss_full = r[20];
    i_flush = (drain == 0) && (sent < NUM_OPS) && (r[26:21] == 6'd0);
  endtask

  // one cycle of the reference model, just before the rising edge
  task automatic model_step();
    int hit;
    logic accept;
    logic issue;
    model_ent_t e;
    model_ent_t keep[$];
    accept = i_haz_valid && o_haz_ready;
    issue  = o_req_valid && i_req_ready;
    occ = model_q.size() + int'(rel_pend);
    if (drain == 0) begin
      check_bit("o_haz_ready", occ != RQ_SIZE, o_haz_ready);
      check_bit("o_almost_full", occ >= RQ_ALMOST_LVL, o_almost_full);
    end
    if (o_req_valid) begin
      check_request(hit);
      if (issue) model_q.delete(hit);
    end
    resolve_model();
    if (i_flush) begin
      foreach (model_q[k]) model_q[k].dead = 1'b1;
    end
    if (accept) begin
      e.pl   = i_haz_payload;
      e.typ  = i_haz_typ;
      e.idx  = i_haz_index;
      e.dead = 1'b0;
      if (e.typ == HAZ_MISS_WAIT) e.idx.miss.unused = '0;
      if (e.typ == HAZ_L1D_CONFLICT) e.idx = '0;
      model_q.push_back(e);
      sent++;
    end
    rel_pend = issue;
    if (i_flush) begin
      drain = DRAIN_CYC;
    end else if (drain > 0) begin
      drain--;
      if (drain == 0) begin
        foreach (model_q[k]) if (!model_q[k].dead) keep.push_back(model_q[k]);
        model_q = keep;  // dead slots have left by now
      end
    end
  endtask

  initial begin
    #(NUM_OPS * 200 * 8);
    $display("watchdog expired before all entries were replayed");
    fail_stop();
  end

  initial begin
    i_reset_n = 1'b0;
    i_haz_valid = 1'b0;
    i_haz_typ = HAZ_STQ_WAIT;
    i_haz_index = '0;
    i_haz_payload = '0;
    i_stq_resolve_mask = '0;
    i_miss_resolve_valid = 1'b0;
    i_miss_resolve_oh = '0;
    i_miss_full = 1'b0;
    i_flush = 1'b0;
    i_req_ready = 1'b0;
    repeat (3) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;
    while (sent < NUM_OPS || model_q.size() != 0 || drain != 0 || rel_pend) begin
      @(negedge i_clk);
      drive_inputs();
      #3;
      model_step();
    end
    @(negedge i_clk);
    i_haz_valid = 1'b0;
    #3;
    check_bit("o_haz_ready", 1'b1, o_haz_ready);
    check_bit("o_almost_full", 1'b0, o_almost_full);
    check_bit("o_req_valid", 1'b0, o_req_valid);
    $display("NO ERRORS");
    $finish;
  end

endmodule

//--- filelist.f
logic/lsu_replay_pkg.sv
logic/replay_alloc_if.sv
logic/replay_issue_if.sv
logic/replay_slot_alloc.sv
logic/replay_hazard_array.sv
logic/replay_issue_arb.sv
logic/lsu_replay_top.sv
verification/lsu_replay_sva.sv
verification/tb_lsu_replay.sv

//--- run_sim.sh
#!/bin/sh
# build and run the replay queue testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_lsu_replay \
  -f filelist.f -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "NO ERRORS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
